// File: hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and storage sizes
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define DMEM_ADDR_W 8
`define DMEM_WORDS  256
`define RESET_PC    32'h0000_0000

// primary opcodes
`define OP_SPECIAL  6'h00
`define OP_ADDIU    6'h09
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// function codes under OP_SPECIAL
`define FN_SLL      6'h00
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2a

// alu select codes
`define ALU_SEL_W   4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLT     4'd5
`define ALU_SLL     4'd6
`define ALU_LUI     4'd7

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    // register-format view of an instruction word
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fmt_t;

    // immediate-format view of the same word
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instr_u           instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       rs_data;
        logic [`XLEN-1:0]       rt_data;
        logic [`XLEN-1:0]       imm32;
        logic [4:0]             shamt;
        logic [`ALU_SEL_W-1:0]  alu_sel;
        logic                   use_imm;
        logic                   mem_rd;
        logic                   mem_wr;
        logic                   rf_wen;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       alu_res;
        logic [`XLEN-1:0]       store_data;
        logic                   mem_rd;
        logic                   mem_wr;
        logic                   rf_wen;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
        logic                   rf_wen;
    } mem_wb_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] wnum;
        logic [`XLEN-1:0]       wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module fetch_unit
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic [`XLEN-1:0] inst_word,
    output logic [`XLEN-1:0] inst_addr,
    output if_id_t           if_id
);

    logic [`XLEN-1:0] pc;

    // word is answered in the same cycle with no wait states
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pc + `XLEN'd4;
        end
    end

    // fetch/decode register frozen on load-use
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= inst_word;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  mem_wb_t                wr
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wen;

    // r0 is never written
    assign wen = wr.valid && wr.rf_wen && (wr.waddr != '0);

    // same-cycle write is visible on the read side
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wen && (addr == wr.waddr)) begin
            return wr.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    output logic    stall,
    output id_ex_t  id_ex
);

    instr_u                 ins;
    logic                   is_rtype;
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`XLEN-1:0]       rs_data;
    logic [`XLEN-1:0]       rt_data;
    logic [`XLEN-1:0]       imm32;
    logic [`ALU_SEL_W-1:0]  alu_sel;
    logic                   use_imm;
    logic                   mem_rd;
    logic                   mem_wr;
    logic                   rf_wen;
    logic                   uses_rs;
    logic                   uses_rt;
    logic                   hit_rs;
    logic                   hit_rt;
    id_ex_t                 id_ex_d;

    assign ins      = if_id.instr;
    assign is_rtype = (ins.r_fmt.opcode == `OP_SPECIAL);
    assign waddr    = is_rtype ? ins.r_fmt.rd : ins.i_fmt.rt;

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (ins.i_fmt.rs),
        .raddr2 (ins.i_fmt.rt),
        .rdata1 (rs_data),
        .rdata2 (rt_data),
        .wr     (mem_wb)
    );

    //////////////////////////////////////////////////////////////////////
    // instruction decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_sel = `ALU_ADD;
        imm32   = {{16{ins.i_fmt.imm[15]}}, ins.i_fmt.imm};
        use_imm = 1'b1;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        rf_wen  = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        case (ins.i_fmt.opcode)
            `OP_SPECIAL: begin
                use_imm = 1'b0;
                uses_rt = 1'b1;
                case (ins.r_fmt.funct)
                    `FN_ADDU: alu_sel = `ALU_ADD;
                    `FN_SUBU: alu_sel = `ALU_SUB;
                    `FN_AND:  alu_sel = `ALU_AND;
                    `FN_OR:   alu_sel = `ALU_OR;
                    `FN_XOR:  alu_sel = `ALU_XOR;
                    `FN_SLT:  alu_sel = `ALU_SLT;
                    `FN_SLL: begin
                        // shifts rt and leaves the rs field unused
                        alu_sel = `ALU_SLL;
                        uses_rs = 1'b0;
                    end
                    default:  rf_wen = 1'b0;
                endcase
            end
            `OP_ADDIU: alu_sel = `ALU_ADD;
            `OP_ANDI: begin
                alu_sel = `ALU_AND;
                imm32   = {16'h0000, ins.i_fmt.imm};
            end
            `OP_ORI: begin
                alu_sel = `ALU_OR;
                imm32   = {16'h0000, ins.i_fmt.imm};
            end
            `OP_LUI: begin
                alu_sel = `ALU_LUI;
                uses_rs = 1'b0;
            end
            `OP_LW: mem_rd = 1'b1;
            `OP_SW: begin
                mem_wr  = 1'b1;
                rf_wen  = 1'b0;
                uses_rt = 1'b1;
            end
            // unknown opcodes retire as nops
            default: begin
                rf_wen  = 1'b0;
                uses_rs = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // load-use against the load sitting in execute
    //////////////////////////////////////////////////////////////////////

    assign hit_rs = uses_rs && (ins.i_fmt.rs == id_ex.waddr);
    assign hit_rt = uses_rt && (ins.i_fmt.rt == id_ex.waddr);
    assign stall  = if_id.valid && id_ex.valid && id_ex.mem_rd && id_ex.rf_wen
                    && (hit_rs || hit_rt);

    always_comb begin
        // bubble while stalled
        id_ex_d.valid   = if_id.valid && !stall;
        id_ex_d.pc      = if_id.pc;
        id_ex_d.rs      = ins.i_fmt.rs;
        id_ex_d.rt      = ins.i_fmt.rt;
        id_ex_d.waddr   = waddr;
        id_ex_d.rs_data = rs_data;
        id_ex_d.rt_data = rt_data;
        id_ex_d.imm32   = imm32;
        id_ex_d.shamt   = ins.r_fmt.shamt;
        id_ex_d.alu_sel = alu_sel;
        id_ex_d.use_imm = use_imm;
        id_ex_d.mem_rd  = mem_rd;
        id_ex_d.mem_wr  = mem_wr;
        id_ex_d.rf_wen  = rf_wen && (waddr != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  id_ex_t  id_ex,
    input  mem_wb_t mem_wb,
    output ex_mem_t ex_mem
);

    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] rt_fwd;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] alu_res;
    ex_mem_t          ex_mem_d;

    // newest producer wins and a load in memory is covered by the stall
    function automatic logic [`XLEN-1:0] fwd_operand(
        input logic [`REG_ADDR_W-1:0] rnum,
        input logic [`XLEN-1:0]       decoded,
        input ex_mem_t                em,
        input mem_wb_t                mw
    );
        if (em.valid && em.rf_wen && !em.mem_rd && (em.waddr == rnum)) begin
            return em.alu_res;
        end
        if (mw.valid && mw.rf_wen && (mw.waddr == rnum)) begin
            return mw.wdata;
        end
        return decoded;
    endfunction

    assign src_a  = fwd_operand(id_ex.rs, id_ex.rs_data, ex_mem, mem_wb);
    assign rt_fwd = fwd_operand(id_ex.rt, id_ex.rt_data, ex_mem, mem_wb);
    assign src_b  = id_ex.use_imm ? id_ex.imm32 : rt_fwd;

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_sel)
            `ALU_ADD: alu_res = src_a + src_b;
            `ALU_SUB: alu_res = src_a - src_b;
            `ALU_AND: alu_res = src_a & src_b;
            `ALU_OR:  alu_res = src_a | src_b;
            `ALU_XOR: alu_res = src_a ^ src_b;
            `ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            `ALU_SLL: alu_res = src_b << id_ex.shamt;
            `ALU_LUI: alu_res = {src_b[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.pc         = id_ex.pc;
        ex_mem_d.waddr      = id_ex.waddr;
        ex_mem_d.alu_res    = alu_res;
        ex_mem_d.store_data = rt_fwd;
        ex_mem_d.mem_rd     = id_ex.mem_rd;
        ex_mem_d.mem_wr     = id_ex.mem_wr;
        ex_mem_d.rf_wen     = id_ex.rf_wen;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module mem_wb_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  ex_mem_t   ex_mem,
    output mem_wb_t   mem_wb,
    output wb_trace_t trace
);

    logic [`XLEN-1:0]        dmem [`DMEM_WORDS];
    logic [`DMEM_ADDR_W-1:0] word_addr;
    logic [`XLEN-1:0]        load_data;
    mem_wb_t                 mem_wb_d;

    // byte address to word index
    assign word_addr = ex_mem.alu_res[`DMEM_ADDR_W+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_wr) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    always_comb begin
        mem_wb_d.valid  = ex_mem.valid;
        mem_wb_d.pc     = ex_mem.pc;
        mem_wb_d.waddr  = ex_mem.waddr;
        mem_wb_d.wdata  = ex_mem.mem_rd ? load_data : ex_mem.alu_res;
        mem_wb_d.rf_wen = ex_mem.rf_wen;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_wb_d;
        end
    end

    // one cycle behind the register file write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trace <= '0;
        end else begin
            trace.valid <= mem_wb.valid && mem_wb.rf_wen;
            if (mem_wb.valid && mem_wb.rf_wen) begin
                trace.pc    <= mem_wb.pc;
                trace.wnum  <= mem_wb.waddr;
                trace.wdata <= mem_wb.wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core (
    input  logic               clk,
    input  logic               rst_n,
    output logic [`XLEN-1:0]   inst_addr,
    input  logic [`XLEN-1:0]   inst_word,
    output cpu_pkg::wb_trace_t trace
);

    logic              stall;
    cpu_pkg::if_id_t   if_id;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_mem_t  ex_mem;
    cpu_pkg::mem_wb_t  mem_wb;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    fetch_unit u_fetch_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .inst_word (inst_word),
        .inst_addr (inst_addr),
        .if_id     (if_id)
    );

    //////////////////////////////////////////////////////////////////////
    // processing
    //////////////////////////////////////////////////////////////////////

    decode_stage u_decode_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .if_id  (if_id),
        .mem_wb (mem_wb),
        .stall  (stall),
        .id_ex  (id_ex)
    );

    execute_stage u_execute_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .mem_wb (mem_wb),
        .ex_mem (ex_mem)
    );

    //////////////////////////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////////////////////////

    mem_wb_stage u_mem_wb_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .trace  (trace)
    );

endmodule

`default_nettype wire

// File: bench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_checker
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  wb_trace_t trace,
    output int        errors,
    output int        seen,
    output int        expected
);

    localparam string STIM_FILE = "bench/cpu_stim.txt";

    logic [`XLEN-1:0]       exp_pc   [$];
    logic [`REG_ADDR_W-1:0] exp_num  [$];
    logic [`XLEN-1:0]       exp_data [$];
    int                     cmp_errors;
    int                     load_errors;

    assign errors = cmp_errors + load_errors;

    task automatic read_expected();
        int               fd;
        logic [8*128-1:0] text_line;
        logic [`XLEN-1:0] f_pc;
        logic [`XLEN-1:0] f_num;
        logic [`XLEN-1:0] f_data;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s for the expected trace", STIM_FILE);
            load_errors++;
            return;
        end
        while ($fgets(text_line, fd) > 0) begin
            if ($sscanf(text_line, "E %h %h %h", f_pc, f_num, f_data) == 3) begin
                exp_pc.push_back(f_pc);
                exp_num.push_back(f_num[`REG_ADDR_W-1:0]);
                exp_data.push_back(f_data);
            end
        end
        $fclose(fd);
        if (exp_pc.size() == 0) begin
            $display("no expected trace entries found in %s", STIM_FILE);
            load_errors++;
        end
    endtask

    task automatic compare_field(input string field, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] want);
        if (got !== want) begin
            $display("ERROR %0t: trace entry %0d field %s is %h, expected %h",
                     $time, seen, field, got, want);
            cmp_errors++;
        end
    endtask

    initial begin
        load_errors = 0;
        read_expected();
        expected = exp_pc.size();
    end

    // trace is registered, so the edge sees last cycle's entry
    always @(posedge clk) begin
        if (!rst_n) begin
            if (trace.valid) begin
                $display("trace entry reported during reset, pc %h", trace.pc);
                cmp_errors++;
            end
        end else if (trace.valid) begin
            if (seen >= expected) begin
                $display("extra trace entry after all expected writes: pc %h reg %0d data %h",
                         trace.pc, trace.wnum, trace.wdata);
                cmp_errors++;
            end else begin
                compare_field("pc", trace.pc, exp_pc[seen]);
                compare_field("wnum", 32'(trace.wnum), 32'(exp_num[seen]));
                compare_field("wdata", trace.wdata, exp_data[seen]);
            end
            seen++;
        end
    end

endmodule

`default_nettype wire

// File: bench/cpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_properties
    import cpu_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic [`XLEN-1:0] inst_addr,
    input logic             stall,
    input wb_trace_t        trace
);

    int fail_count;

    no_trace_in_reset: assert property (@(posedge clk) !rst_n |-> !trace.valid)
        else begin
            $error("trace valid while reset is asserted");
            fail_count++;
        end

    // r0 writes are dropped in decode
    no_r0_trace: assert property (@(posedge clk) disable iff (!rst_n)
                                  trace.valid |-> (trace.wnum != '0))
        else begin
            $error("trace reports a write to r0");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk) inst_addr[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            fail_count++;
        end

    stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
                                     stall |=> $stable(inst_addr))
        else begin
            $error("fetch address moved after a stall cycle");
            fail_count++;
        end

endmodule

bind cpu_core cpu_properties u_cpu_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_addr (inst_addr),
    .stall     (stall),
    .trace     (trace)
);

`default_nettype wire

// File: bench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam string STIM_FILE    = "bench/cpu_stim.txt";
    localparam int    PROG_MAX     = 256;
    localparam int    WAIT_CYCLES  = 2000;
    localparam int    DRAIN_CYCLES = 20;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] inst_addr;
    logic [`XLEN-1:0] inst_word;
    wb_trace_t        trace;

    logic [`XLEN-1:0] prog [PROG_MAX];
    int               prog_len;

    int chk_errors;
    int chk_seen;
    int chk_expected;
    int assert_errors;
    int bench_errors;

    cpu_core u_cpu_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_addr (inst_addr),
        .inst_word (inst_word),
        .trace     (trace)
    );

    cpu_checker u_cpu_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .trace    (trace),
        .errors   (chk_errors),
        .seen     (chk_seen),
        .expected (chk_expected)
    );

    assign assert_errors = u_cpu_core.u_cpu_properties.fail_count;

    always #4 clk = ~clk;

    // fetch responder returns a nop past the program end
    always_comb begin
        if (int'(inst_addr[`XLEN-1:2]) < prog_len) begin
            inst_word = prog[inst_addr[9:2]];
        end else begin
            inst_word = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // program load and trace wait
    //////////////////////////////////////////////////////////////////////

    task automatic load_program();
        int                fd;
        logic [8*128-1:0]  text_line;
        logic [`XLEN-1:0]  word;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s for reading", STIM_FILE);
            bench_errors++;
            return;
        end
        while ($fgets(text_line, fd) > 0) begin
            if ($sscanf(text_line, "I %h", word) == 1 && prog_len < PROG_MAX) begin
                prog[prog_len[7:0]] = word;
                prog_len++;
            end
        end
        $fclose(fd);
        if (prog_len == 0) begin
            $display("no program words found in %s", STIM_FILE);
            bench_errors++;
        end
    endtask

    task automatic wait_for_trace();
        int cycles;
        cycles = 0;
        // counts are sampled away from the active edge
        while (chk_seen < chk_expected && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (chk_seen < chk_expected) begin
            $display("timeout: %0d of %0d expected trace entries never arrived",
                     chk_expected - chk_seen, chk_expected);
            bench_errors++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        prog_len     = 0;
        bench_errors = 0;
        load_program();
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        wait_for_trace();
        // a few more cycles to catch stray entries
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("error counts: checker %0d, assertions %0d, bench %0d",
                 chk_errors, assert_errors, bench_errors);
        if (chk_errors == 0 && assert_errors == 0 && bench_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/cpu_stim.txt
# I <instruction word, hex>            program from address 0, one word per line
# E <pc> <register> <write data>       expected trace entries in program order, all hex
I 24011234  # 00 addiu r1, r0, 0x1234
I 2402fffd  # 04 addiu r2, r0, -3
I 3c038000  # 08 lui   r3, 0x8000
I 3404ff00  # 0c ori   r4, r0, 0xff00
I 30458f0f  # 10 andi  r5, r2, 0x8f0f   distance 3 on r2
I 00223021  # 14 addu  r6, r1, r2
I 00c13823  # 18 subu  r7, r6, r1       distance 1 on r6
I 00c44024  # 1c and   r8, r6, r4       distance 2 on r6
I 00e34826  # 20 xor   r9, r7, r3
I 01055025  # 24 or    r10, r8, r5
I 0061582a  # 28 slt   r11, r3, r1      negative less than positive
I 0022602a  # 2c slt   r12, r1, r2
I 000b6900  # 30 sll   r13, r11, 4
I 00210021  # 34 addu  r0, r1, r1       no trace
I 000d7021  # 38 addu  r14, r0, r13
I ada90008  # 3c sw    r9, 8(r13)       stores to 0x18
I 8c0f0018  # 40 lw    r15, 0x18(r0)
I 01e18021  # 44 addu  r16, r15, r1     load-use on rs
I 26110001  # 48 addiu r17, r16, 1
I 00119040  # 4c sll   r18, r17, 1
I 8c130018  # 50 lw    r19, 0x18(r0)
I 0033a023  # 54 subu  r20, r1, r19     load-use on rt
I 24550005  # 58 addiu r21, r2, 5       wraps to 2
E 00000000 01 00001234
E 00000004 02 fffffffd
E 00000008 03 80000000
E 0000000c 04 0000ff00
E 00000010 05 00008f0d
E 00000014 06 00001231
E 00000018 07 fffffffd
E 0000001c 08 00001200
E 00000020 09 7ffffffd
E 00000024 0a 00009f0d
E 00000028 0b 00000001
E 0000002c 0c 00000000
E 00000030 0d 00000010
E 00000038 0e 00000010
E 00000040 0f 7ffffffd
E 00000044 10 80001231
E 00000048 11 80001232
E 0000004c 12 00002464
E 00000050 13 7ffffffd
E 00000054 14 80001237
E 00000058 15 00000002

// File: vlog.f
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_core.sv
bench/cpu_checker.sv
bench/cpu_properties.sv
bench/tb_cpu.sv

// File: Makefile
# Verilator build, run and lint for the cpu_core testbench

TOP := tb_cpu

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "sim passed" sim.log || (echo "FAIL: see sim.log"; exit 1)
	@echo "PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir sim.log
